// ==== upsampler_pkg.sv ====
package upsampler_pkg;

    // audio and coefficient widths
    localparam int SAMPLE_W   = 24;
    localparam int COEFF_W    = 16;
    // coefficients are Q1.15
    localparam int PROD_SHIFT = 15;
    localparam int NUM_CH     = 2;

    // coefficient address fields
    localparam int PHASE_W = 1;
    localparam int TAP_W   = 5;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [COEFF_W-1:0]  coeff_t;

    // multiplier operands, all zero when idle so channels can be OR-ed
    typedef struct packed {
        sample_t mcand;
        coeff_t  mplier;
    } mac_req_t;

    // coefficient table address, all zero when not granted
    typedef struct packed {
        logic [PHASE_W-1:0] phase;
        logic [TAP_W-1:0]   tap;
    } coeff_addr_t;

    typedef enum logic [1:0] {
        CH_IDLE,
        CH_RESULT,
        CH_CALC,
        CH_NEXT_PHASE
    } ch_state_e;

    // halfband interpolator split in two phases, index is phase * 32 + tap
    // phase 0 holds the half-sample offsets of a windowed sinc
    // phase 1 is the pass-through phase, a single center tap
    localparam coeff_t COEFF_TABLE [64] = '{
        -80,    170,    -270,   380,    -500,   630,    -780,   950,
        -1150,  1390,   -1700,  2150,   -2850,  4080,   -6900,  20860,
        20860,  -6900,  4080,   -2850,  2150,   -1700,  1390,   -1150,
        950,    -780,   630,    -500,   380,    -270,   170,    -80,
        0,      0,      0,      0,      0,      0,      0,      0,
        0,      0,      0,      0,      0,      0,      0,      32767,
        0,      0,      0,      0,      0,      0,      0,      0,
        0,      0,      0,      0,      0,      0,      0,      0
    };

endpackage

// ==== sample_ringbuf.sv ====
`timescale 1ns/1ps

module sample_ringbuf #(
    parameter int RB_LEN = 64
) (
    input  logic                         clk,
    input  logic                         rst,
    input  upsampler_pkg::sample_t       data_i,
    input  logic                         we_i,
    input  logic                         pop_i,
    input  logic [$clog2(RB_LEN)-1:0]    offset_i,
    output upsampler_pkg::sample_t       data_o
);

    localparam int AW = $clog2(RB_LEN);

    upsampler_pkg::sample_t mem [RB_LEN];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW-1:0] rd_addr;

    // pointers wrap on their own since RB_LEN is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (we_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wr_ptr] <= data_i;
        end
    end

    // tap j sits j places after the oldest sample
    assign rd_addr = rd_ptr + offset_i;
    assign data_o  = mem[rd_addr];

endmodule

// ==== mac_share.sv ====
`timescale 1ns/1ps

module mac_share #(
    parameter int FIRDEPTH     = 32,
    parameter int NUM_FIR      = 2,
    parameter int MULT_LATENCY = 4
) (
    input  logic                                              clk,
    input  logic                                              rst,
    input  logic [upsampler_pkg::NUM_CH-1:0]                  out_pop_i,
    output logic [upsampler_pkg::NUM_CH-1:0]                  grant_o,
    input  upsampler_pkg::coeff_addr_t [upsampler_pkg::NUM_CH-1:0] addr_i,
    input  upsampler_pkg::mac_req_t [upsampler_pkg::NUM_CH-1:0]    req_i,
    output upsampler_pkg::coeff_t                             coeff_o,
    output upsampler_pkg::sample_t                            prod_o
);

    localparam int CH_AW  = $clog2(upsampler_pkg::NUM_CH);
    localparam int TBL_AW = $clog2(FIRDEPTH * NUM_FIR);
    localparam int FULL_W = upsampler_pkg::SAMPLE_W + upsampler_pkg::COEFF_W;

    logic [CH_AW-1:0]            last_ch;
    upsampler_pkg::coeff_addr_t  addr_or;
    upsampler_pkg::mac_req_t     req_or;
    logic [TBL_AW-1:0]           tbl_idx;
    logic signed [FULL_W-1:0]    full_prod;
    upsampler_pkg::sample_t      prod_next;
    upsampler_pkg::sample_t      prod_pipe [MULT_LATENCY];

    // the channel popped last owns the multiplier
    always_ff @(posedge clk) begin
        if (rst) begin
            last_ch <= '0;
        end else begin
            for (int c = 0; c < upsampler_pkg::NUM_CH; c++) begin
                if (out_pop_i[c]) begin
                    last_ch <= CH_AW'(c);
                end
            end
        end
    end

    always_comb begin
        for (int c = 0; c < upsampler_pkg::NUM_CH; c++) begin
            grant_o[c] = (last_ch == CH_AW'(c));
        end
    end

    // ungranted channels drive zero, so a plain OR merges them
    always_comb begin
        addr_or = '0;
        req_or  = '0;
        for (int c = 0; c < upsampler_pkg::NUM_CH; c++) begin
            addr_or = addr_or | addr_i[c];
            req_or  = req_or | req_i[c];
        end
    end

    assign tbl_idx = TBL_AW'(addr_or.phase * FIRDEPTH + addr_or.tap);
    assign coeff_o = upsampler_pkg::COEFF_TABLE[tbl_idx];

    // full product scaled back to sample range, upper bits dropped
    assign full_prod = $signed(req_or.mcand) * $signed(req_or.mplier);
    assign prod_next = upsampler_pkg::sample_t'(full_prod >>> upsampler_pkg::PROD_SHIFT);

    always_ff @(posedge clk) begin
        prod_pipe[0] <= prod_next;
        for (int i = 1; i < MULT_LATENCY; i++) begin
            prod_pipe[i] <= prod_pipe[i-1];
        end
    end

    assign prod_o = prod_pipe[MULT_LATENCY-1];

endmodule

// ==== polyphase_channel.sv ====
`timescale 1ns/1ps

module polyphase_channel #(
    parameter int FIRDEPTH     = 32,
    parameter int NUM_FIR      = 2,
    parameter int MULT_LATENCY = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          grant_i,

    // coefficient table
    output upsampler_pkg::coeff_addr_t    coeff_addr_o,
    input  upsampler_pkg::coeff_t         coeff_i,

    // shared multiplier
    output upsampler_pkg::mac_req_t       mac_req_o,
    input  upsampler_pkg::sample_t        prod_i,

    // ring buffer
    output logic                          rb_pop_o,
    output logic [$clog2(FIRDEPTH)-1:0]   rb_offset_o,
    input  upsampler_pkg::sample_t        rb_data_i,

    // consumer side
    input  logic                          pop_i,
    output upsampler_pkg::sample_t        data_o,
    output logic                          ack_o
);

    // load, multiply, accumulate
    localparam int PIPE_DEPTH = 1 + MULT_LATENCY + 1;
    localparam int TAP_AW     = $clog2(FIRDEPTH);
    localparam int CNT_W      = $clog2(FIRDEPTH + PIPE_DEPTH);
    localparam int PH_W       = $clog2(NUM_FIR);

    localparam logic [CNT_W-1:0] LAST_CNT  = CNT_W'(FIRDEPTH + PIPE_DEPTH - 1);
    localparam logic [CNT_W-1:0] ACC_START = CNT_W'(PIPE_DEPTH - 1);

    upsampler_pkg::ch_state_e  state;
    logic [CNT_W-1:0]          tap_cnt;
    logic [PH_W-1:0]           phase_q;
    logic                      last_phase;
    upsampler_pkg::sample_t    result_q;
    upsampler_pkg::sample_t    sample_q;
    upsampler_pkg::coeff_t     coeff_q;
    logic                      load_en;

    assign last_phase = (phase_q == PH_W'(NUM_FIR - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= upsampler_pkg::CH_IDLE;
            tap_cnt  <= '0;
            phase_q  <= '0;
            result_q <= '0;
        end else begin
            // counter rests at zero outside the calc state
            tap_cnt <= '0;
            case (state)
                upsampler_pkg::CH_IDLE: begin
                    if (pop_i) begin
                        state <= upsampler_pkg::CH_RESULT;
                    end
                end
                upsampler_pkg::CH_RESULT: begin
                    // old result goes out on ack this cycle
                    result_q <= '0;
                    if (grant_i) begin
                        state <= upsampler_pkg::CH_CALC;
                    end
                end
                upsampler_pkg::CH_CALC: begin
                    // product of tap 0 arrives once the pipe is full
                    if (tap_cnt >= ACC_START) begin
                        result_q <= result_q + prod_i;
                    end
                    if (tap_cnt == LAST_CNT) begin
                        state <= upsampler_pkg::CH_NEXT_PHASE;
                    end else begin
                        tap_cnt <= tap_cnt + 1'b1;
                    end
                end
                upsampler_pkg::CH_NEXT_PHASE: begin
                    phase_q <= last_phase ? '0 : phase_q + 1'b1;
                    state   <= upsampler_pkg::CH_IDLE;
                end
                default: begin
                    state <= upsampler_pkg::CH_IDLE;
                end
            endcase
        end
    end

    // load stage, zero past the last tap so the trailing product adds nothing
    assign load_en = grant_i && (state == upsampler_pkg::CH_CALC) &&
                     (tap_cnt < CNT_W'(FIRDEPTH));

    always_ff @(posedge clk) begin
        if (load_en) begin
            sample_q <= rb_data_i;
            coeff_q  <= coeff_i;
        end else begin
            sample_q <= '0;
            coeff_q  <= '0;
        end
    end

    assign mac_req_o.mcand  = sample_q;
    assign mac_req_o.mplier = coeff_q;

    always_comb begin
        coeff_addr_o = '0;
        if (grant_i) begin
            coeff_addr_o.phase = phase_q;
            coeff_addr_o.tap   = tap_cnt[TAP_AW-1:0];
        end
    end

    assign rb_offset_o = tap_cnt[TAP_AW-1:0];

    // oldest sample retires after the last phase has used it
    assign rb_pop_o = (state == upsampler_pkg::CH_NEXT_PHASE) && last_phase;

    assign ack_o  = (state == upsampler_pkg::CH_RESULT);
    assign data_o = ack_o ? result_q : '0;

endmodule

// ==== stereo_upsampler.sv ====
`timescale 1ns/1ps

module stereo_upsampler #(
    parameter int FIRDEPTH     = 32,
    parameter int NUM_FIR      = 2,
    parameter int MULT_LATENCY = 4,
    parameter int RB_LEN       = 64
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  upsampler_pkg::sample_t               in_sample_i,
    input  logic [upsampler_pkg::NUM_CH-1:0]     in_we_i,
    output logic [upsampler_pkg::NUM_CH-1:0]     in_pop_o,
    input  logic [upsampler_pkg::NUM_CH-1:0]     out_pop_i,
    output upsampler_pkg::sample_t               out_data_o,
    output logic [upsampler_pkg::NUM_CH-1:0]     out_ack_o
);

    localparam int NUM_CH = upsampler_pkg::NUM_CH;
    localparam int TAP_AW = $clog2(FIRDEPTH);
    localparam int RB_AW  = $clog2(RB_LEN);

    logic [NUM_CH-1:0]                        grant;
    upsampler_pkg::coeff_addr_t [NUM_CH-1:0]  ch_addr;
    upsampler_pkg::mac_req_t [NUM_CH-1:0]     ch_req;
    upsampler_pkg::coeff_t                    coeff;
    upsampler_pkg::sample_t                   prod;

    logic [NUM_CH-1:0]       rb_pop;
    logic [TAP_AW-1:0]       rb_offset  [NUM_CH];
    logic [RB_AW-1:0]        rb_off_ext [NUM_CH];
    upsampler_pkg::sample_t  rb_data    [NUM_CH];
    upsampler_pkg::sample_t  ch_data    [NUM_CH];

    mac_share #(
        .FIRDEPTH     (FIRDEPTH),
        .NUM_FIR      (NUM_FIR),
        .MULT_LATENCY (MULT_LATENCY)
    ) u_mac_share (
        .clk       (clk),
        .rst       (rst),
        .out_pop_i (out_pop_i),
        .grant_o   (grant),
        .addr_i    (ch_addr),
        .req_i     (ch_req),
        .coeff_o   (coeff),
        .prod_o    (prod)
    );

    for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
        // ring buffer is deeper than the filter for input slack
        assign rb_off_ext[c] = RB_AW'(rb_offset[c]);

        sample_ringbuf #(
            .RB_LEN (RB_LEN)
        ) u_ringbuf (
            .clk      (clk),
            .rst      (rst),
            .data_i   (in_sample_i),
            .we_i     (in_we_i[c]),
            .pop_i    (rb_pop[c]),
            .offset_i (rb_off_ext[c]),
            .data_o   (rb_data[c])
        );

        polyphase_channel #(
            .FIRDEPTH     (FIRDEPTH),
            .NUM_FIR      (NUM_FIR),
            .MULT_LATENCY (MULT_LATENCY)
        ) u_channel (
            .clk          (clk),
            .rst          (rst),
            .grant_i      (grant[c]),
            .coeff_addr_o (ch_addr[c]),
            .coeff_i      (coeff),
            .mac_req_o    (ch_req[c]),
            .prod_i       (prod),
            .rb_pop_o     (rb_pop[c]),
            .rb_offset_o  (rb_offset[c]),
            .rb_data_i    (rb_data[c]),
            .pop_i        (out_pop_i[c]),
            .data_o       (ch_data[c]),
            .ack_o        (out_ack_o[c])
        );
    end

    assign in_pop_o = rb_pop;

    // each channel drives zero unless it is acking
    always_comb begin
        out_data_o = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            out_data_o = out_data_o | ch_data[c];
        end
    end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_o
);

    // reset drops on a rising edge, like the DUT's synchronous reset expects
    initial begin
        clk_o = 1'b0;
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// ==== tb_stereo_upsampler.sv ====
`timescale 1ns/1ps

module tb_stereo_upsampler;

    localparam int FIRDEPTH     = 32;
    localparam int NUM_FIR      = 2;
    localparam int MULT_LATENCY = 4;
    localparam int RB_LEN       = 64;
    localparam int NUM_CH       = upsampler_pkg::NUM_CH;
    localparam int CALC_CYCLES  = FIRDEPTH + MULT_LATENCY + 2;
    localparam int ACK_TIMEOUT  = 16;
    localparam int HIST_LEN     = 1024;
    localparam upsampler_pkg::sample_t POS_FS = 24'sh7fffff;
    localparam upsampler_pkg::sample_t NEG_FS = 24'sh800000;

    logic                    clk;
    logic                    rst;
    upsampler_pkg::sample_t  in_sample;
    logic [NUM_CH-1:0]       in_we;
    logic [NUM_CH-1:0]       in_pop;
    logic [NUM_CH-1:0]       out_pop;
    upsampler_pkg::sample_t  out_data;
    logic [NUM_CH-1:0]       out_ack;

    // reference model state, one history of written samples per channel
    upsampler_pkg::sample_t  hist [NUM_CH][HIST_LEN];
    upsampler_pkg::sample_t  prev_res [NUM_CH];
    int wr_cnt [NUM_CH];
    int rd_idx [NUM_CH];
    int phase [NUM_CH];
    int pops_seen [NUM_CH];
    int errors = 0;
    int checks = 0;
    int seed = 51550;
    int fill_mode = 0;
    int pattern_base = 0;

    tb_clock_gen #(.PERIOD_NS(8), .RST_CYCLES(2)) u_clock_gen (.clk_o(clk), .rst_o(rst));

    stereo_upsampler #(
        .FIRDEPTH     (FIRDEPTH),
        .NUM_FIR      (NUM_FIR),
        .MULT_LATENCY (MULT_LATENCY),
        .RB_LEN       (RB_LEN)
    ) UUT (
        .clk         (clk),
        .rst         (rst),
        .in_sample_i (in_sample),
        .in_we_i     (in_we),
        .in_pop_o    (in_pop),
        .out_pop_i   (out_pop),
        .out_data_o  (out_data),
        .out_ack_o   (out_ack)
    );

    function automatic logic [NUM_CH-1:0] chan_mask(input int ch);
        return NUM_CH'(1) << ch;
    endfunction

    // each tap product is scaled and cut to 24 bits, the sum wraps at 24 bits
    function automatic upsampler_pkg::sample_t model_result(input int ch);
        upsampler_pkg::sample_t acc;
        longint full;
        acc = '0;
        for (int j = 0; j < FIRDEPTH; j++) begin
            full = longint'(hist[ch][rd_idx[ch] + j]) *
                   longint'(upsampler_pkg::COEFF_TABLE[phase[ch] * FIRDEPTH + j]);
            acc = acc + upsampler_pkg::sample_t'(full >>> upsampler_pkg::PROD_SHIFT);
        end
        return acc;
    endfunction

    task automatic check_sample(input string name, input upsampler_pkg::sample_t got,
                                input upsampler_pkg::sample_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_ack(input logic [NUM_CH-1:0] got, input logic [NUM_CH-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: out_ack_o got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic check_pop(input logic [NUM_CH-1:0] got, input logic [NUM_CH-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: in_pop_o got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic write_sample(input int ch, input upsampler_pkg::sample_t value);
        @(posedge clk);
        in_sample <= value;
        in_we     <= chan_mask(ch);
        hist[ch][wr_cnt[ch]] = value;
        wr_cnt[ch]++;
        @(posedge clk);
        in_we <= '0;
    endtask

    // keep a full tap window buffered, well inside the ring depth
    task automatic top_up(input int ch);
        upsampler_pkg::sample_t value;
        int k;
        while (wr_cnt[ch] - rd_idx[ch] < FIRDEPTH) begin
            k = wr_cnt[ch] - pattern_base;
            case (fill_mode)
                1: value = upsampler_pkg::sample_t'($random(seed));
                // sample sign follows phase 0 coefficient sign, sums overflow
                2: value = (upsampler_pkg::COEFF_TABLE[k % FIRDEPTH] < 0) ? NEG_FS : POS_FS;
                default: value = '0;
            endcase
            write_sample(ch, value);
        end
    endtask

    task automatic request(input int ch);
        upsampler_pkg::sample_t expected;
        logic [NUM_CH-1:0] pop_pattern;
        int waited;
        top_up(ch);
        expected = prev_res[ch];
        prev_res[ch] = model_result(ch);
        @(posedge clk);
        out_pop <= chan_mask(ch);
        @(posedge clk);
        out_pop <= '0;
        waited = 0;
        @(negedge clk);
        while (out_ack === '0 && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= ACK_TIMEOUT) begin
            errors++;
            $display("no ack from channel %0d within %0d cycles", ch, ACK_TIMEOUT);
        end else begin
            check_count("ack latency", waited, 0);
            check_ack(out_ack, chan_mask(ch));
            check_sample("out_data_o", out_data, expected);
            pop_pattern = '0;
            // busy window of the channel, after which it accepts a new pop
            for (int i = 0; i < CALC_CYCLES + 2; i++) begin
                @(negedge clk);
                if (i == 0) begin
                    check_ack(out_ack, '0);
                    check_sample("out_data_o", out_data, '0);
                end
                pop_pattern = pop_pattern | in_pop;
                for (int c = 0; c < NUM_CH; c++) begin
                    if (in_pop[c]) begin
                        pops_seen[c]++;
                    end
                end
            end
            check_pop(pop_pattern, (phase[ch] == NUM_FIR - 1) ? chan_mask(ch) : '0);
            if (phase[ch] == NUM_FIR - 1) begin
                rd_idx[ch]++;
            end
            phase[ch] = (phase[ch] + 1) % NUM_FIR;
        end
    endtask

    task automatic report_test(input string name, input int start_err);
        $display("test %s done with %0d errors", name, errors - start_err);
    endtask

    initial begin
        int waited;
        int start_err;
        int p0;
        int p1;
        in_sample = '0;
        in_we     = '0;
        out_pop   = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            wr_cnt[c]    = 0;
            rd_idx[c]    = 0;
            phase[c]     = 0;
            pops_seen[c] = 0;
            prev_res[c]  = '0;
        end
        waited = 0;
        while (rst !== 1'b0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (rst !== 1'b0) begin
            $display("reset was never released");
            $display("Test failures found");
            $finish;
        end else begin
            // first result on each channel is the cleared one
            start_err = errors;
            @(negedge clk);
            check_ack(out_ack, '0);
            check_pop(in_pop, '0);
            request(0);
            request(1);
            report_test("reset", start_err);

            // impulse walks through every tap of both phases
            start_err = errors;
            write_sample(0, POS_FS);
            repeat (66) request(0);
            report_test("impulse", start_err);

            start_err = errors;
            fill_mode = 1;
            repeat (40) begin
                request(0);
                request(1);
            end
            report_test("random stereo", start_err);

            start_err = errors;
            p0 = pops_seen[0];
            p1 = pops_seen[1];
            repeat (4) begin
                request(0);
                request(0);
                request(1);
                request(1);
            end
            check_count("in_pop_o[0] pulses", pops_seen[0] - p0, 4);
            check_count("in_pop_o[1] pulses", pops_seen[1] - p1, 4);
            report_test("input pop", start_err);

            start_err = errors;
            fill_mode = 2;
            pattern_base = wr_cnt[1];
            repeat (70) request(1);
            report_test("full scale", start_err);

            $display("%0d checks, %0d errors", checks, errors);
            if (errors == 0) begin
                $display("All tests passed!");
            end else begin
                $display("Test failures found");
            end
            $finish;
        end
    end

endmodule

// ==== stereo_upsampler.f ====
upsampler_pkg.sv
sample_ringbuf.sv
mac_share.sv
polyphase_channel.sv
stereo_upsampler.sv
tb_clock_gen.sv
tb_stereo_upsampler.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_stereo_upsampler
FILELIST  ?= stereo_upsampler.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= All tests passed!

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)

check: run
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "simulation passed"; \
	else echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
